// ==== fetch_top.f ====
hw/fetch_pkg.sv
hw/fifo_queue.sv
hw/warp_scheduler.sv
hw/fetch_unit.sv
hw/icache_pipe.sv
hw/instr_buffer.sv
hw/fetch_top.sv
tests/fetch_tb.sv

// ==== tests/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    // outputs are read late in the cycle, long after the drive settled
    localparam int SAMPLE_DELAY  = 15;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 4;
    localparam int PHASE2_CYCLES = 2000;
    localparam int STIM_CYCLES   = RESET_CYCLES + IDLE_CYCLES + NUM_WARPS + PHASE2_CYCLES;
    // one warp is held for WINDOW_LEN cycles out of every WINDOW_PERIOD
    localparam int WINDOW_PERIOD = 250;
    localparam int WINDOW_START  = 100;
    localparam int WINDOW_LEN    = 40;
    localparam int WINDOW_MIN    = 3;
    localparam int MIN_POPS      = 100;

    logic                 clk;
    logic                 reset;
    logic                 start_valid;
    wid_t                 start_wid;
    pc_t                  start_pc;
    logic                 redirect_valid;
    wid_t                 redirect_wid;
    pc_t                  redirect_pc;
    logic [NUM_WARPS-1:0] deq_ready;
    logic [NUM_WARPS-1:0] deq_valid;
    fetch_out_t           deq_data [NUM_WARPS];

    // model state, one next PC per warp plus delivery counters
    pc_t                  expected_pc  [NUM_WARPS];
    int                   pop_total    [NUM_WARPS];
    int                   window_pops  [NUM_WARPS];
    logic [NUM_WARPS-1:0] ready_pick;
    logic                 in_window;
    logic                 do_redirect;
    logic                 progress_ok;
    wid_t                 held_wid;
    wid_t                 rd_wid;
    pc_t                  rd_pc;
    int                   short_wid;

    fetch_top DUT (
        .clk            (clk),
        .reset          (reset),
        .start_valid    (start_valid),
        .start_wid      (start_wid),
        .start_pc       (start_pc),
        .redirect_valid (redirect_valid),
        .redirect_wid   (redirect_wid),
        .redirect_pc    (redirect_pc),
        .deq_ready      (deq_ready),
        .deq_valid      (deq_valid),
        .deq_data       (deq_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic halt_failed();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        halt_failed();
    endtask

    task automatic check_val(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t signal=%s got=%0h expected=%0h", $time, name, actual, expected);
            halt_failed();
        end
    endtask

    // the program image puts word address bits 15:0 on top and their complement below
    function automatic instr_t expected_instr(input pc_t pc);
        return {pc[17:2], ~pc[17:2]};
    endfunction

    function automatic pc_t random_aligned_pc();
        logic [31:0] r;
        r = $urandom();
        return {r[29:0], 2'b00};
    endfunction

    // every handshake seen this cycle must match the model's next PC for that warp
    task automatic observe_pops();
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (deq_valid[w] && deq_ready[w]) begin
                check_val($sformatf("deq_data[%0d].wid", w), deq_data[w].wid, w);
                check_val($sformatf("deq_data[%0d].pc", w), deq_data[w].pc, expected_pc[w]);
                check_val($sformatf("deq_data[%0d].instr", w), deq_data[w].instr,
                          expected_instr(expected_pc[w]));
                check_val($sformatf("deq_data[%0d].tmask", w), deq_data[w].tmask, 4'hf);
                expected_pc[w] = expected_pc[w] + 32'd4;
                pop_total[w]++;
                window_pops[w]++;
            end
        end
    endtask

    // one clock: drive after the edge, then sample near the end of the cycle
    task automatic drive_cycle(input logic st_v, input wid_t st_w, input pc_t st_pc,
                               input logic rd_v, input wid_t rd_w, input pc_t rd_pc,
                               input logic [NUM_WARPS-1:0] ready);
        @(posedge clk);
        #DRIVE_DELAY;
        start_valid    = st_v;
        start_wid      = st_w;
        start_pc       = st_pc;
        redirect_valid = rd_v;
        redirect_wid   = rd_w;
        redirect_pc    = rd_pc;
        deq_ready      = ready;
        // starts and redirects only happen with deq_ready all low, so no pop races them
        if (st_v) expected_pc[st_w] = st_pc;
        if (rd_v) expected_pc[rd_w] = rd_pc;
        #SAMPLE_DELAY;
        observe_pops();
    endtask

    // while one warp sits on a full backlog the others must still get fetch slots
    task automatic check_window(input wid_t held);
        check_val("held warp deq_valid", deq_valid[held], 1);
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (w != held && window_pops[w] < WINDOW_MIN) begin
                report_problem($sformatf("warp %0d popped only %0d times while warp %0d was held",
                                         w, window_pops[w], held));
            end
        end
    endtask

    initial begin
        #(2 * STIM_CYCLES * CLK_PERIOD);
        report_problem("watchdog expired before the stimulus finished");
    end

    initial begin
        void'($urandom(32'he955_cb8e));
        reset          = 1'b1;
        start_valid    = 1'b0;
        start_wid      = '0;
        start_pc       = '0;
        redirect_valid = 1'b0;
        redirect_wid   = '0;
        redirect_pc    = '0;
        deq_ready      = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            expected_pc[w] = '0;
            pop_total[w]   = 0;
            window_pops[w] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // no warp is active yet, so nothing may show up at the buffer heads
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
            check_val("deq_valid", deq_valid, 0);
        end

        for (int w = 0; w < NUM_WARPS; w++) begin
            drive_cycle(1'b1, wid_t'(w), random_aligned_pc(), 1'b0, '0, '0, '0);
        end

        for (int cyc = 0; cyc < PHASE2_CYCLES; cyc++) begin
            in_window = (cyc % WINDOW_PERIOD) >= WINDOW_START &&
                        (cyc % WINDOW_PERIOD) < WINDOW_START + WINDOW_LEN;
            held_wid  = wid_t'((cyc / WINDOW_PERIOD) % NUM_WARPS);
            if (cyc % WINDOW_PERIOD == WINDOW_START) begin
                for (int w = 0; w < NUM_WARPS; w++) window_pops[w] = 0;
            end
            for (int w = 0; w < NUM_WARPS; w++) begin
                ready_pick[w] = ($urandom_range(99, 0) < 70);
            end
            rd_wid      = wid_t'($urandom_range(NUM_WARPS - 1, 0));
            rd_pc       = random_aligned_pc();
            // redirects stay out of the hold windows so the counts stay meaningful
            do_redirect = !in_window && ($urandom_range(63, 0) == 0);
            if (do_redirect) begin
                ready_pick = '0;
            end else if (in_window) begin
                ready_pick[held_wid] = 1'b0;
            end
            drive_cycle(1'b0, '0, '0, do_redirect, rd_wid, rd_pc, ready_pick);
            if (cyc % WINDOW_PERIOD == WINDOW_START + WINDOW_LEN - 1) begin
                check_window(held_wid);
            end
        end

        // squashes must not starve any warp over the whole run
        progress_ok = 1'b1;
        short_wid   = 0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (progress_ok && pop_total[w] < MIN_POPS) begin
                progress_ok = 1'b0;
                short_wid   = w;
            end
        end
        if (progress_ok) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_problem($sformatf("warp %0d delivered only %0d instructions, minimum is %0d",
                                     short_wid, pop_total[short_wid], MIN_POPS));
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_valid,
    input  wid_t                 start_wid,
    input  pc_t                  start_pc,
    input  logic                 redirect_valid,
    input  wid_t                 redirect_wid,
    input  pc_t                  redirect_pc,
    input  logic [NUM_WARPS-1:0] deq_ready,
    output logic [NUM_WARPS-1:0] deq_valid,
    output fetch_out_t           deq_data [NUM_WARPS]
);
    logic                 sched_valid;
    logic                 sched_ready;
    sched_req_t           sched_req;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    icache_req_t          mem_req;
    logic                 mem_rsp_valid;
    logic                 mem_rsp_ready;
    icache_rsp_t          mem_rsp;
    logic                 fetch_valid;
    fetch_out_t           fetch_out;
    logic                 buf_ready;
    // pops feed both the pending counters and the resume PCs
    logic [NUM_WARPS-1:0] deq_pop;

    warp_scheduler scheduler (
        .clk            (clk),
        .reset          (reset),
        .start_valid    (start_valid),
        .start_wid      (start_wid),
        .start_pc       (start_pc),
        .redirect_valid (redirect_valid),
        .redirect_wid   (redirect_wid),
        .redirect_pc    (redirect_pc),
        .deq_pop        (deq_pop),
        .sched_valid    (sched_valid),
        .sched_req      (sched_req),
        .sched_ready    (sched_ready)
    );

    fetch_unit fetch (
        .clk            (clk),
        .reset          (reset),
        .sched_valid    (sched_valid),
        .sched_req      (sched_req),
        .sched_ready    (sched_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .fetch_valid    (fetch_valid),
        .fetch_out      (fetch_out),
        .buf_ready      (buf_ready),
        .deq_pop        (deq_pop),
        .redirect_valid (redirect_valid)
    );

    icache_pipe icache (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    instr_buffer ibuf (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .fetch_valid    (fetch_valid),
        .fetch_out      (fetch_out),
        .buf_ready      (buf_ready),
        .deq_ready      (deq_ready),
        .deq_valid      (deq_valid),
        .deq_data       (deq_data),
        .deq_pop        (deq_pop)
    );

endmodule

// ==== hw/instr_buffer.sv ====
`timescale 1ns/10ps

module instr_buffer import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 redirect_valid,
    input  logic                 fetch_valid,
    input  fetch_out_t           fetch_out,
    output logic                 buf_ready,
    input  logic [NUM_WARPS-1:0] deq_ready,
    output logic [NUM_WARPS-1:0] deq_valid,
    output fetch_out_t           deq_data [NUM_WARPS],
    output logic [NUM_WARPS-1:0] deq_pop
);
    logic [NUM_WARPS-1:0] fifo_full;
    logic [NUM_WARPS-1:0] fifo_empty;
    logic [NUM_WARPS-1:0] fifo_push;

    // only the FIFO of the arriving warp matters for back-pressure
    assign buf_ready = !fifo_full[fetch_out.wid];

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        // steer by warp id
        assign fifo_push[w] = fetch_valid && buf_ready && (fetch_out.wid == wid_t'(w));
        assign deq_valid[w] = !fifo_empty[w];
        // a pop is a completed handshake with the consumer
        assign deq_pop[w]   = deq_valid[w] && deq_ready[w];

        // everything buffered is wrong-path after a redirect
        fifo_queue #(
            .DATA_W ($bits(fetch_out_t)),
            .DEPTH  (IBUF_DEPTH)
        ) warp_fifo (
            .clk   (clk),
            .reset (reset),
            .flush (redirect_valid),
            .push  (fifo_push[w]),
            .pop   (deq_pop[w]),
            .din   (fetch_out),
            .dout  (deq_data[w]),
            .full  (fifo_full[w]),
            .empty (fifo_empty[w])
        );
    end

endmodule

// ==== hw/icache_pipe.sv ====
`timescale 1ns/10ps

module icache_pipe import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_req_valid,
    input  icache_req_t mem_req,
    output logic        mem_req_ready,
    output logic        mem_rsp_valid,
    output icache_rsp_t mem_rsp,
    input  logic        mem_rsp_ready
);
    logic [ICACHE_LATENCY-1:0] stage_valid;
    icache_rsp_t               stage_data [ICACHE_LATENCY];
    logic                      advance;

    // the whole pipe moves together, so a stalled head freezes every stage
    assign advance       = !stage_valid[ICACHE_LATENCY-1] || mem_rsp_ready;
    assign mem_req_ready = advance;

    // last stage is the response port
    assign mem_rsp_valid = stage_valid[ICACHE_LATENCY-1];
    assign mem_rsp       = stage_data[ICACHE_LATENCY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[ICACHE_LATENCY-2:0], mem_req_valid};
        end
    end

    // image lookup happens on entry, later stages only carry the word along
    always_ff @(posedge clk) begin
        if (advance) begin
            stage_data[0] <= '{data: image_word(mem_req.addr), wid: mem_req.wid};
            for (int i = 1; i < ICACHE_LATENCY; i++) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sched_valid,
    input  sched_req_t           sched_req,
    output logic                 sched_ready,
    output logic                 mem_req_valid,
    output icache_req_t          mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  icache_rsp_t          mem_rsp,
    output logic                 mem_rsp_ready,
    output logic                 fetch_valid,
    output fetch_out_t           fetch_out,
    input  logic                 buf_ready,
    input  logic [NUM_WARPS-1:0] deq_pop,
    input  logic                 redirect_valid
);
    // one-entry request register feeding the memory
    logic                    req_valid_q;
    sched_req_t              req_q;
    pend_cnt_t               pend_cnt [NUM_WARPS];
    logic [NUM_WARPS-1:0]    pend_full;
    flight_cnt_t             flight_cnt;
    flight_cnt_t             flight_cnt_n;
    logic                    squashing;
    // the redirect cycle itself already drops traffic
    logic                    squash_now;
    logic                    sched_fire;
    logic                    mem_req_fire;
    logic                    mem_rsp_fire;
    logic                    tag_pop;
    logic                    tag_full;
    logic [XLEN+TMASK_W-1:0] tag_dout;

    assign squash_now = squashing || redirect_valid;

    // pending counts span request register, memory, tag store and buffer
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            pend_full[w] = (pend_cnt[w] == pend_cnt_t'(IBUF_DEPTH));
        end
    end

    assign mem_req_valid = req_valid_q && !squash_now && !tag_full;
    assign mem_req       = '{addr: req_q.pc[XLEN-1:2], wid: req_q.wid};
    assign mem_req_fire  = mem_req_valid && mem_req_ready;

    // the register takes a new entry when empty or when its entry leaves this cycle
    assign sched_ready = !pend_full[sched_req.wid] && (!req_valid_q || mem_req_fire);
    assign sched_fire  = sched_valid && sched_ready;

    always_ff @(posedge clk) begin
        if (reset || redirect_valid) begin
            req_valid_q <= 1'b0;
        end else if (sched_fire) begin
            req_valid_q <= 1'b1;
        end else if (mem_req_fire) begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sched_fire) begin
            req_q <= sched_req;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (reset || redirect_valid) begin
                pend_cnt[w] <= '0;
            end else begin
                pend_cnt[w] <= pend_cnt[w]
                             + pend_cnt_t'(sched_fire && sched_req.wid == wid_t'(w))
                             - pend_cnt_t'(deq_pop[w]);
            end
        end
    end

    // PC and mask wait here in request order since the memory answers in order
    fifo_queue #(
        .DATA_W (XLEN + TMASK_W),
        .DEPTH  (TAG_DEPTH)
    ) tag_store (
        .clk   (clk),
        .reset (reset),
        .flush (redirect_valid),
        .push  (mem_req_fire),
        .pop   (tag_pop),
        .din   ({req_q.pc, req_q.tmask}),
        .dout  (tag_dout),
        .full  (tag_full),
        .empty ()
    );

    // squashed responses are accepted and thrown away
    assign mem_rsp_ready = squash_now || buf_ready;
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;
    assign fetch_valid   = mem_rsp_valid && !squash_now;
    assign tag_pop       = fetch_valid && buf_ready;
    assign fetch_out     = '{wid:   mem_rsp.wid,
                             pc:    tag_dout[XLEN+TMASK_W-1:TMASK_W],
                             tmask: tag_dout[TMASK_W-1:0],
                             instr: mem_rsp.data};

    assign flight_cnt_n = flight_cnt + flight_cnt_t'(mem_req_fire) - flight_cnt_t'(mem_rsp_fire);

    always_ff @(posedge clk) begin
        if (reset) begin
            flight_cnt <= '0;
            squashing  <= 1'b0;
        end else begin
            flight_cnt <= flight_cnt_n;
            // stays up until everything sent before the redirect has drained
            if (redirect_valid) begin
                squashing <= 1'b1;
            end else if (squashing) begin
                squashing <= (flight_cnt_n != '0);
            end
        end
    end

endmodule

// ==== hw/warp_scheduler.sv ====
`timescale 1ns/10ps

module warp_scheduler import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_valid,
    input  wid_t                 start_wid,
    input  pc_t                  start_pc,
    input  logic                 redirect_valid,
    input  wid_t                 redirect_wid,
    input  pc_t                  redirect_pc,
    input  logic [NUM_WARPS-1:0] deq_pop,
    output logic                 sched_valid,
    output sched_req_t           sched_req,
    input  logic                 sched_ready
);
    logic [NUM_WARPS-1:0] active;
    // fetch_pc is the next PC to request, resume_pc the next PC the consumer expects
    pc_t                  fetch_pc    [NUM_WARPS];
    pc_t                  resume_pc   [NUM_WARPS];
    pc_t                  resume_next [NUM_WARPS];
    wid_t                 last_wid;
    wid_t                 pick_wid;
    logic                 pick_found;
    logic                 sched_fire;

    // search starts just after the warp offered last, so a capped warp cannot hog the slot
    always_comb begin
        wid_t cand;
        pick_found = 1'b0;
        pick_wid   = last_wid;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            cand = last_wid + wid_t'(i);
            if (!pick_found && active[cand]) begin
                pick_found = 1'b1;
                pick_wid   = cand;
            end
        end
    end

    // nothing is offered while PCs are being reloaded
    assign sched_valid = pick_found && !redirect_valid;
    assign sched_req   = '{wid: pick_wid, pc: fetch_pc[pick_wid], tmask: '1};
    assign sched_fire  = sched_valid && sched_ready;

    // a pop in the same cycle as a redirect still counts as delivered
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            resume_next[w] = deq_pop[w] ? resume_pc[w] + pc_t'(4) : resume_pc[w];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= '0;
            last_wid <= '0;
        end else begin
            // rotate on every offer, taken or not
            if (sched_valid) begin
                last_wid <= pick_wid;
            end
            if (start_valid) begin
                active[start_wid] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (redirect_valid && redirect_wid == wid_t'(w)) begin
                fetch_pc[w]  <= redirect_pc;
                resume_pc[w] <= redirect_pc;
            end else if (redirect_valid) begin
                // buffered work is flushed, so refetch from the first undelivered PC
                fetch_pc[w]  <= resume_next[w];
                resume_pc[w] <= resume_next[w];
            end else if (start_valid && start_wid == wid_t'(w)) begin
                fetch_pc[w]  <= start_pc;
                resume_pc[w] <= start_pc;
            end else begin
                if (sched_fire && pick_wid == wid_t'(w)) begin
                    fetch_pc[w] <= fetch_pc[w] + pc_t'(4);
                end
                resume_pc[w] <= resume_next[w];
            end
        end
    end

endmodule

// ==== hw/fifo_queue.sv ====
`timescale 1ns/10ps

module fifo_queue #(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              push,
    input  logic              pop,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout,
    output logic              full,
    output logic              empty
);
    logic [DATA_W-1:0]          mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty   = (count == '0);
    // requests against a full or empty queue are simply ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    // head entry is always visible, valid only while not empty
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // a push and a pop in the same cycle leave the count alone
            count <= count + ($clog2(DEPTH+1))'(do_push) - ($clog2(DEPTH+1))'(do_pop);
        end
    end

    // storage holds payload only
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // core shape: four warps of four threads each
    localparam int NUM_WARPS      = 4;
    localparam int WID_W          = 2;
    localparam int XLEN           = 32;
    localparam int TMASK_W        = 4;

    // instruction memory is addressed in 32-bit words
    localparam int ADDR_W         = 30;
    localparam int ICACHE_LATENCY = 2;

    // a warp never has more fetches pending than its buffer can hold
    localparam int IBUF_DEPTH     = 4;
    // tag store covers the request register and the memory pipe with room to spare
    localparam int TAG_DEPTH      = 8;

    typedef logic [WID_W-1:0]                  wid_t;
    typedef logic [XLEN-1:0]                   pc_t;
    typedef logic [ADDR_W-1:0]                 word_addr_t;
    typedef logic [XLEN-1:0]                   instr_t;
    typedef logic [TMASK_W-1:0]                tmask_t;
    typedef logic [$clog2(IBUF_DEPTH+1)-1:0]   pend_cnt_t;
    typedef logic [$clog2(TAG_DEPTH+1)-1:0]    flight_cnt_t;

    // one fetch offered by the scheduler
    typedef struct packed {
        wid_t   wid;
        pc_t    pc;
        tmask_t tmask;
    } sched_req_t;

    // the memory only needs the word address and the warp for routing
    typedef struct packed {
        word_addr_t addr;
        wid_t       wid;
    } icache_req_t;

    typedef struct packed {
        instr_t data;
        wid_t   wid;
    } icache_rsp_t;

    // what the instruction buffer stores for each warp
    typedef struct packed {
        wid_t   wid;
        pc_t    pc;
        tmask_t tmask;
        instr_t instr;
    } fetch_out_t;

    // program image: low address half on top, its complement below
    function automatic instr_t image_word(input word_addr_t addr);
        return {addr[15:0], ~addr[15:0]};
    endfunction

endpackage
